/* source/mem_bus_defines.svh */
`ifndef MEM_BUS_DEFINES_SVH
`define MEM_BUS_DEFINES_SVH

// byte address and data word
`define ADDR_W 32
`define DATA_W 32

// memory depth in words
`define MEM_WORDS 1024

// extra cycles of busy per access
`define MEM_WAIT 2

`endif

/* source/mem_bus_pkg.sv */
`include "mem_bus_defines.svh"

package mem_bus_pkg;

	////////////////////////////////////////////////////////////////////////////
	// generic bus, ren/wen/busy
	typedef struct packed {
		logic                    ren;
		logic                    wen;
		logic [`ADDR_W-1:0]      addr;
		logic [`DATA_W-1:0]      wdata;
		logic [`DATA_W/8-1:0]    byte_en;
	} bus_req_t;

	typedef struct packed {
		logic                    busy;     // low for one cycle on completion
		logic [`DATA_W-1:0]      rdata;
	} bus_resp_t;

	////////////////////////////////////////////////////////////////////////////
	// core side
	typedef enum logic [1:0] {SIZE_BYTE, SIZE_HALF, SIZE_WORD} access_size_t;

	typedef struct packed {
		logic                    valid;
		logic                    write;
		access_size_t            size;
		logic                    sign_ext;
		logic [`ADDR_W-1:0]      addr;
		logic [`DATA_W-1:0]      wdata;
	} ls_req_t;

	typedef struct packed {
		logic                    valid;
		logic [`DATA_W-1:0]      rdata;
	} ls_resp_t;

	typedef struct packed {
		logic                    valid;
		logic [`ADDR_W-1:0]      pc;
		logic [`DATA_W-1:0]      instr;
	} instr_t;

endpackage

/* source/memory_arbiter.sv */
`timescale 1ns/100ps

module memory_arbiter (
	input  logic                   CLK,
	input  logic                   nRST,
	input  mem_bus_pkg::bus_req_t  ibus_req,
	input  mem_bus_pkg::bus_req_t  dbus_req,
	output mem_bus_pkg::bus_resp_t ibus_resp,
	output mem_bus_pkg::bus_resp_t dbus_resp,
	output mem_bus_pkg::bus_req_t  mem_req,
	input  mem_bus_pkg::bus_resp_t mem_resp
);
	typedef enum logic [1:0] {IDLE, IREQUEST, DREQUEST} state_t;

	state_t state, next_state;

	mem_bus_pkg::bus_req_t  next_mem_req;
	mem_bus_pkg::bus_resp_t next_ibus_resp;
	mem_bus_pkg::bus_resp_t next_dbus_resp;

	logic ipend;
	logic dpend;

	// a master seeing busy low right now is finishing and its request is stale
	assign ipend = (ibus_req.ren || ibus_req.wen) && ibus_resp.busy;
	assign dpend = (dbus_req.ren || dbus_req.wen) && dbus_resp.busy;

	////////////////////////////////////////////////////////////////////////////
	// registered outputs
	always_ff @(posedge CLK, negedge nRST) begin : OUTPUT_FF
		if (!nRST) begin
			ibus_resp.busy  <= 1'b1;
			ibus_resp.rdata <= '0;
			dbus_resp.busy  <= 1'b1;
			dbus_resp.rdata <= '0;
			mem_req         <= '0;
		end else begin
			ibus_resp <= next_ibus_resp;
			dbus_resp <= next_dbus_resp;
			mem_req   <= next_mem_req;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin : STATE_FF
		if (!nRST) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// grant selection and forwarding
	always_comb begin : NEXT_LOGIC
		next_state           = state;
		next_mem_req         = '0;
		next_ibus_resp.busy  = 1'b1;
		next_ibus_resp.rdata = '0;
		next_dbus_resp.busy  = 1'b1;
		next_dbus_resp.rdata = '0;

		case (state)
			IDLE: begin
				if (dpend) begin                  // data side first
					next_mem_req = dbus_req;
					next_state   = DREQUEST;
				end else if (ipend) begin
					next_mem_req = ibus_req;
					next_state   = IREQUEST;
				end
			end
			IREQUEST: begin
				if (mem_resp.busy) begin
					next_mem_req = ibus_req;
				end else begin
					next_ibus_resp = mem_resp;    // completion, request dropped
					next_state     = IDLE;
				end
			end
			DREQUEST: begin
				if (mem_resp.busy) begin
					next_mem_req = dbus_req;
				end else begin
					next_dbus_resp = mem_resp;
					next_state     = IDLE;
				end
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

endmodule

/* source/instr_fetch_unit.sv */
`timescale 1ns/100ps
`include "mem_bus_defines.svh"

module instr_fetch_unit (
	input  logic                   CLK,
	input  logic                   nRST,
	input  logic                   redirect,
	input  logic [`ADDR_W-1:0]     redirect_pc,
	output mem_bus_pkg::instr_t    instr,
	input  logic                   instr_ready,
	output mem_bus_pkg::bus_req_t  bus_req,
	input  mem_bus_pkg::bus_resp_t bus_resp
);
	logic                running;               // set by first redirect
	logic                fetching;
	logic                discard;               // in-flight word is stale
	logic [`ADDR_W-1:0]  pc_q;
	logic [`ADDR_W-1:0]  req_pc;
	logic [`ADDR_W-1:0]  q_pc [2];
	logic [`DATA_W-1:0]  q_word [2];
	logic [1:0]          count;
	logic                done;
	logic                push;
	logic                pop;
	logic                issue;

	assign done  = fetching && !bus_resp.busy;
	assign push  = done && !discard && !redirect;
	assign pop   = instr.valid && instr_ready && !redirect;
	assign issue = running && !fetching && (count != 2'd2) && !redirect;

	always_ff @(posedge CLK, negedge nRST) begin : CTRL_FF
		if (!nRST) begin
			running  <= 1'b0;
			fetching <= 1'b0;
			discard  <= 1'b0;
			pc_q     <= '0;
			count    <= '0;
		end else begin
			if (issue) begin
				fetching <= 1'b1;
			end else if (done) begin
				fetching <= 1'b0;
			end
			if (redirect) begin
				running <= 1'b1;
				pc_q    <= redirect_pc;
				count   <= '0;                     // flush
				discard <= fetching && !done;
			end else begin
				count <= count + 2'(push) - 2'(pop);
				if (done) begin
					discard <= 1'b0;
				end
				if (push) begin
					pc_q <= pc_q + `ADDR_W'(4);
				end
			end
		end
	end

	// queue holds at most one entry when a fetch completes
	always_ff @(posedge CLK) begin : QUEUE_FF
		if (issue) begin
			req_pc <= pc_q;
		end
		if (push && pop) begin
			q_pc[0]   <= req_pc;
			q_word[0] <= bus_resp.rdata;
		end else if (push) begin
			q_pc[count[0]]   <= req_pc;
			q_word[count[0]] <= bus_resp.rdata;
		end else if (pop) begin
			q_pc[0]   <= q_pc[1];
			q_word[0] <= q_word[1];
		end
	end

	assign instr.valid = (count != 2'd0);
	assign instr.pc    = q_pc[0];
	assign instr.instr = q_word[0];

	assign bus_req.ren     = fetching;
	assign bus_req.wen     = 1'b0;
	assign bus_req.addr    = req_pc;
	assign bus_req.wdata   = '0;
	assign bus_req.byte_en = '1;

endmodule

/* source/load_store_unit.sv */
`timescale 1ns/100ps
`include "mem_bus_defines.svh"

module load_store_unit (
	input  logic                   CLK,
	input  logic                   nRST,
	input  mem_bus_pkg::ls_req_t   ls_req,
	output logic                   ls_ready,
	output mem_bus_pkg::ls_resp_t  ls_resp,
	output mem_bus_pkg::bus_req_t  bus_req,
	input  mem_bus_pkg::bus_resp_t bus_resp
);
	logic                        active;
	logic                        write_q;
	logic                        sign_q;
	mem_bus_pkg::access_size_t   size_q;
	logic [1:0]                  offs_q;
	logic [`ADDR_W-1:0]          addr_q;
	logic [`DATA_W-1:0]          wdata_q;
	logic [`DATA_W/8-1:0]        byte_en_q;
	logic                        accept;
	logic                        done;
	logic [1:0]                  offs;
	logic [`DATA_W/8-1:0]        byte_en;
	logic [`DATA_W-1:0]          lane_data;
	logic [`DATA_W-1:0]          shifted;
	logic [`DATA_W-1:0]          ld_data;

	assign accept = ls_req.valid && ls_ready;
	assign done   = active && !bus_resp.busy;

	always_comb begin : STORE_STEER
		case (ls_req.size)
			mem_bus_pkg::SIZE_BYTE: begin
				offs      = ls_req.addr[1:0];
				byte_en   = 4'b0001 << offs;
				lane_data = {4{ls_req.wdata[7:0]}};     // same byte on every lane
			end
			mem_bus_pkg::SIZE_HALF: begin
				offs      = {ls_req.addr[1], 1'b0};      // truncated to halfword
				byte_en   = 4'b0011 << offs;
				lane_data = {2{ls_req.wdata[15:0]}};
			end
			default: begin
				offs      = 2'b00;
				byte_en   = '1;
				lane_data = ls_req.wdata;
			end
		endcase
	end

	always_ff @(posedge CLK, negedge nRST) begin : CTRL_FF
		if (!nRST) begin
			active   <= 1'b0;
			ls_ready <= 1'b0;
		end else if (accept) begin
			active   <= 1'b1;
			ls_ready <= 1'b0;
		end else if (done) begin
			active   <= 1'b0;
			ls_ready <= 1'b1;
		end else begin
			ls_ready <= !active;
		end
	end

	always_ff @(posedge CLK) begin : CMD_FF
		if (accept) begin
			write_q   <= ls_req.write;
			sign_q    <= ls_req.sign_ext;
			size_q    <= ls_req.size;
			offs_q    <= offs;
			addr_q    <= {ls_req.addr[`ADDR_W-1:2], 2'b00};
			wdata_q   <= lane_data;
			byte_en_q <= byte_en;
		end
	end

	// load lanes down to bit 0 then extend
	assign shifted = bus_resp.rdata >> {offs_q, 3'b000};

	always_comb begin : LOAD_EXTEND
		case (size_q)
			mem_bus_pkg::SIZE_BYTE: ld_data = {{(`DATA_W-8){sign_q && shifted[7]}}, shifted[7:0]};
			mem_bus_pkg::SIZE_HALF: ld_data = {{(`DATA_W-16){sign_q && shifted[15]}}, shifted[15:0]};
			default:                ld_data = shifted;
		endcase
	end

	assign bus_req.ren     = active && !write_q;
	assign bus_req.wen     = active && write_q;
	assign bus_req.addr    = addr_q;
	assign bus_req.wdata   = wdata_q;
	assign bus_req.byte_en = byte_en_q;

	assign ls_resp.valid = done;                   // stores complete here too
	assign ls_resp.rdata = write_q ? '0 : ld_data;

endmodule

/* source/wait_state_ram.sv */
`timescale 1ns/100ps
`include "mem_bus_defines.svh"

module wait_state_ram (
	input  logic                   CLK,
	input  logic                   nRST,
	input  mem_bus_pkg::bus_req_t  req,
	output mem_bus_pkg::bus_resp_t resp
);
	localparam int IDX_W = $clog2(`MEM_WORDS);
	localparam int CNT_W = $clog2(`MEM_WAIT + 2);
	localparam int LANES = `DATA_W / 8;

	logic [`DATA_W-1:0] mem [`MEM_WORDS];
	logic [CNT_W-1:0]   wait_cnt;
	logic               access;
	logic               done;
	logic [IDX_W-1:0]   idx;

	assign access = req.ren || req.wen;
	assign done   = access && (wait_cnt == CNT_W'(`MEM_WAIT));
	assign idx    = req.addr[IDX_W+1:2];          // word index above byte offset

	always_ff @(posedge CLK, negedge nRST) begin : WAIT_FF
		if (!nRST) begin
			wait_cnt <= '0;
		end else if (done || !access) begin
			wait_cnt <= '0;                        // ready for next access
		end else begin
			wait_cnt <= wait_cnt + CNT_W'(1);
		end
	end

	always_ff @(posedge CLK) begin : WRITE_PORT
		if (done && req.wen) begin
			for (int i = 0; i < LANES; i++) begin
				if (req.byte_en[i])
					mem[idx][8*i +: 8] <= req.wdata[8*i +: 8];
			end
		end
	end

	// busy high whenever no access is completing
	assign resp.busy  = !done;
	assign resp.rdata = done ? mem[idx] : '0;

endmodule

/* source/mem_subsystem.sv */
`timescale 1ns/100ps
`include "mem_bus_defines.svh"

module mem_subsystem (
	input  logic                  CLK,
	input  logic                  nRST,
	input  logic                  redirect,
	input  logic [`ADDR_W-1:0]    redirect_pc,
	output mem_bus_pkg::instr_t   instr,
	input  logic                  instr_ready,
	input  mem_bus_pkg::ls_req_t  ls_req,
	output logic                  ls_ready,
	output mem_bus_pkg::ls_resp_t ls_resp
);
	mem_bus_pkg::bus_req_t  ibus_req;
	mem_bus_pkg::bus_resp_t ibus_resp;
	mem_bus_pkg::bus_req_t  dbus_req;
	mem_bus_pkg::bus_resp_t dbus_resp;
	mem_bus_pkg::bus_req_t  mem_req;
	mem_bus_pkg::bus_resp_t mem_resp;

	////////////////////////////////////////////////////////////////////////////
	// bus masters
	instr_fetch_unit instr_fetch_unit_inst (
		.CLK(CLK), .nRST(nRST),
		.redirect(redirect), .redirect_pc(redirect_pc),
		.instr(instr), .instr_ready(instr_ready),
		.bus_req(ibus_req), .bus_resp(ibus_resp)
	);

	load_store_unit load_store_unit_inst (
		.CLK(CLK), .nRST(nRST),
		.ls_req(ls_req), .ls_ready(ls_ready), .ls_resp(ls_resp),
		.bus_req(dbus_req), .bus_resp(dbus_resp)
	);

	////////////////////////////////////////////////////////////////////////////
	// shared memory path
	memory_arbiter memory_arbiter_inst (
		.CLK(CLK), .nRST(nRST),
		.ibus_req(ibus_req), .dbus_req(dbus_req),
		.ibus_resp(ibus_resp), .dbus_resp(dbus_resp),
		.mem_req(mem_req), .mem_resp(mem_resp)
	);

	wait_state_ram wait_state_ram_inst (
		.CLK(CLK), .nRST(nRST),
		.req(mem_req), .resp(mem_resp)
	);

endmodule

/* tb/mem_subsystem_checker.sv */
`timescale 1ns/100ps

module mem_subsystem_checker (
	input logic                   CLK,
	input logic                   nRST,
	input mem_bus_pkg::bus_req_t  mem_req,
	input mem_bus_pkg::bus_resp_t mem_resp,
	input mem_bus_pkg::bus_resp_t ibus_resp,
	input mem_bus_pkg::bus_resp_t dbus_resp
);
	int fail_count;

	initial begin
		fail_count = 0;
	end

	single_direction: assert property (@(posedge CLK) disable iff (!nRST)
		!(mem_req.ren && mem_req.wen))
	else begin
		$error("mem_req has ren and wen high together");
		fail_count = fail_count + 1;
	end

	// a granted request holds until the memory completes it
	req_stable: assert property (@(posedge CLK) disable iff (!nRST)
		(mem_req.ren || mem_req.wen) && mem_resp.busy |=> $stable(mem_req))
	else begin
		$error("mem_req changed while the memory was busy");
		fail_count = fail_count + 1;
	end

	single_completion: assert property (@(posedge CLK) disable iff (!nRST)
		ibus_resp.busy || dbus_resp.busy)
	else begin
		$error("both masters see busy low in the same cycle");
		fail_count = fail_count + 1;
	end

endmodule

bind memory_arbiter mem_subsystem_checker checker_inst (
	.CLK(CLK), .nRST(nRST),
	.mem_req(mem_req), .mem_resp(mem_resp),
	.ibus_resp(ibus_resp), .dbus_resp(dbus_resp)
);

/* tb/tb_mem_subsystem.sv */
`timescale 1ns/100ps
`include "mem_bus_defines.svh"

module tb_mem_subsystem;

	// bus accesses per test, fetches included
	localparam int ACCESSES     = 16 + 38 + 32 + 11 + 25 + 16 + 26;
	localparam int LIMIT_CYCLES = ACCESSES * (`MEM_WAIT + 6) + 400;   // reset and stalls

	logic                  CLK;
	logic                  nRST;
	logic                  redirect;
	logic [`ADDR_W-1:0]    redirect_pc;
	logic                  instr_ready;
	mem_bus_pkg::instr_t   instr;
	mem_bus_pkg::ls_req_t  ls_req;
	logic                  ls_ready;
	mem_bus_pkg::ls_resp_t ls_resp;

	logic [7:0]            model [`MEM_WORDS*4];   // byte image of stores issued
	logic [`ADDR_W-1:0]    fetch_pc;
	integer                seed;

	mem_subsystem mem_subsystem_inst (
		.CLK(CLK), .nRST(nRST),
		.redirect(redirect), .redirect_pc(redirect_pc),
		.instr(instr), .instr_ready(instr_ready),
		.ls_req(ls_req), .ls_ready(ls_ready), .ls_resp(ls_resp)
	);

	always #4 CLK = ~CLK;

	////////////////////////////////////////////////////////////////////////////
	// reference model and compare tasks
	function automatic logic [`DATA_W-1:0] model_word(input logic [`ADDR_W-1:0] addr);
		int a;
		a = int'({addr[`ADDR_W-1:2], 2'b00});
		return {model[a+3], model[a+2], model[a+1], model[a]};
	endfunction

	function automatic logic [`DATA_W-1:0] expected_load(input logic [`ADDR_W-1:0] addr,
			input mem_bus_pkg::access_size_t size, input logic sign_ext);
		int a;
		logic [`DATA_W-1:0] value;
		a = int'(addr);
		case (size)
			mem_bus_pkg::SIZE_BYTE: value = {{(`DATA_W-8){sign_ext && model[a][7]}}, model[a]};
			mem_bus_pkg::SIZE_HALF: begin
				a     = int'({addr[`ADDR_W-1:1], 1'b0});
				value = {{(`DATA_W-16){sign_ext && model[a+1][7]}}, model[a+1], model[a]};
			end
			default: value = model_word(addr);
		endcase
		return value;
	endfunction

	task automatic update_model(input logic [`ADDR_W-1:0] addr,
			input mem_bus_pkg::access_size_t size, input logic [`DATA_W-1:0] wdata);
		int a;
		case (size)
			mem_bus_pkg::SIZE_BYTE: model[int'(addr)] = wdata[7:0];
			mem_bus_pkg::SIZE_HALF: begin
				a = int'({addr[`ADDR_W-1:1], 1'b0});
				model[a]   = wdata[7:0];
				model[a+1] = wdata[15:8];
			end
			default: begin
				a = int'({addr[`ADDR_W-1:2], 2'b00});
				for (int i = 0; i < 4; i++)
					model[a+i] = wdata[8*i +: 8];
			end
		endcase
	endtask

	task automatic abort_run();
		$display("TB FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_ls_resp(input mem_bus_pkg::ls_resp_t got,
			input logic [`DATA_W-1:0] expected);
		if (got.rdata !== expected) begin
			$display("** Error: ls_resp.rdata = %h, expected %h", got.rdata, expected);
			abort_run();
		end
	endtask

	task automatic check_instr(input mem_bus_pkg::instr_t got,
			input logic [`ADDR_W-1:0] exp_pc, input logic [`DATA_W-1:0] exp_word);
		if (got.pc !== exp_pc) begin
			$display("** Error: instr.pc = %h, expected %h", got.pc, exp_pc);
			abort_run();
		end else if (got.instr !== exp_word) begin
			$display("** Error: instr.instr = %h, expected %h", got.instr, exp_word);
			abort_run();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// load/store and fetch drivers, all on the falling edge
	task automatic run_access(input logic write, input mem_bus_pkg::access_size_t size,
			input logic sign_ext, input logic [`ADDR_W-1:0] addr,
			input logic [`DATA_W-1:0] wdata, output mem_bus_pkg::ls_resp_t resp);
		@(negedge CLK);
		while (!ls_ready) @(negedge CLK);
		ls_req.valid    = 1'b1;
		ls_req.write    = write;
		ls_req.size     = size;
		ls_req.sign_ext = sign_ext;
		ls_req.addr     = addr;
		ls_req.wdata    = wdata;
		@(negedge CLK);
		ls_req.valid = 1'b0;
		if (ls_ready !== 1'b0) begin
			$display("** Error: ls_ready = %h after a request, expected 0", ls_ready);
			abort_run();
		end
		while (!ls_resp.valid) @(negedge CLK);
		resp = ls_resp;
		@(negedge CLK);
		if (ls_resp.valid !== 1'b0) begin
			$display("** Error: ls_resp.valid = %h one cycle after completion, expected 0",
				ls_resp.valid);
			abort_run();
		end
	endtask

	task automatic store_data(input mem_bus_pkg::access_size_t size,
			input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] wdata);
		mem_bus_pkg::ls_resp_t resp;
		run_access(1'b1, size, 1'b0, addr, wdata, resp);
		update_model(addr, size, wdata);
	endtask

	task automatic load_and_check(input mem_bus_pkg::access_size_t size,
			input logic sign_ext, input logic [`ADDR_W-1:0] addr);
		mem_bus_pkg::ls_resp_t resp;
		logic [`DATA_W-1:0] expected;
		expected = expected_load(addr, size, sign_ext);
		run_access(1'b0, size, sign_ext, addr, '0, resp);
		check_ls_resp(resp, expected);
	endtask

	task automatic redirect_fetch(input logic [`ADDR_W-1:0] pc);
		@(negedge CLK);
		redirect    = 1'b1;
		redirect_pc = pc;
		@(negedge CLK);
		redirect = 1'b0;
	endtask

	// an entry seen valid with ready high pops at the next rising edge
	task automatic collect_instrs(input int count, inout logic [`ADDR_W-1:0] pc);
		int n;
		n = 0;
		while (n < count) begin
			@(negedge CLK);
			instr_ready = 1'b1;
			if (instr.valid) begin
				check_instr(instr, pc, model_word(pc));
				pc = pc + 4;
				n++;
			end
		end
	endtask

	task automatic stall_fetch(input int cycles);
		@(negedge CLK);
		instr_ready = 1'b0;
		repeat (cycles) @(negedge CLK);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	task automatic word_round_trip();
		for (int i = 0; i < 8; i++)
			store_data(mem_bus_pkg::SIZE_WORD, 36 * i, $random(seed));
		for (int i = 0; i < 8; i++)
			load_and_check(mem_bus_pkg::SIZE_WORD, 1'b0, 36 * i);
	endtask

	task automatic subword_access();
		for (int i = 0; i < 4; i++)
			store_data(mem_bus_pkg::SIZE_WORD, 'h300 + 4 * i, $random(seed));
		store_data(mem_bus_pkg::SIZE_BYTE, 'h301, 'h80);        // negative byte
		store_data(mem_bus_pkg::SIZE_BYTE, 'h306, $random(seed));
		store_data(mem_bus_pkg::SIZE_BYTE, 'h30b, $random(seed));
		store_data(mem_bus_pkg::SIZE_HALF, 'h302, $random(seed));
		store_data(mem_bus_pkg::SIZE_HALF, 'h30a, 'h8001);      // negative half
		store_data(mem_bus_pkg::SIZE_HALF, 'h30e, $random(seed));
		for (int i = 0; i < 16; i++)
			load_and_check(mem_bus_pkg::SIZE_BYTE, i[0], 'h300 + i);
		for (int i = 0; i < 8; i++)
			load_and_check(mem_bus_pkg::SIZE_HALF, i[0], 'h300 + 2 * i);
		for (int i = 0; i < 4; i++)
			load_and_check(mem_bus_pkg::SIZE_WORD, 1'b0, 'h300 + 4 * i);
	endtask

	task automatic load_program();
		for (int i = 0; i < 32; i++)
			store_data(mem_bus_pkg::SIZE_WORD, 'h200 + 4 * i, $random(seed));
	endtask

	task automatic sequential_fetch();
		if (instr.valid !== 1'b0) begin
			$display("** Error: instr.valid = %h before the first redirect, expected 0",
				instr.valid);
			abort_run();
		end
		redirect_fetch('h200);
		fetch_pc = 'h200;
		collect_instrs(8, fetch_pc);
	endtask

	task automatic back_pressure();
		stall_fetch(40);                        // queue fills, fetching stops
		collect_instrs(8, fetch_pc);
		collect_instrs(3, fetch_pc);
		stall_fetch(20);
		collect_instrs(3, fetch_pc);
	endtask

	task automatic mid_stream_redirect();
		stall_fetch(20);
		redirect_fetch('h210);                  // full queue thrown away
		fetch_pc = 'h210;
		collect_instrs(2, fetch_pc);
		redirect_fetch('h230);                  // likely with a fetch in flight
		fetch_pc = 'h230;
		collect_instrs(4, fetch_pc);
		stall_fetch(2);
	endtask

	task automatic ls_traffic();
		for (int i = 0; i < 6; i++)
			store_data(mem_bus_pkg::SIZE_WORD, 'h380 + 4 * i, $random(seed));
		for (int i = 0; i < 6; i++)
			load_and_check(mem_bus_pkg::access_size_t'(i % 3), i[0],
				'h380 + 4 * i + ((i % 3 == 2) ? 0 : 2));
	endtask

	task automatic shared_contention();
		redirect_fetch('h200);
		fetch_pc = 'h200;
		fork
			collect_instrs(12, fetch_pc);
			ls_traffic();
		join
		stall_fetch(2);
	endtask

	////////////////////////////////////////////////////////////////////////////
	initial begin : WATCHDOG
		repeat (LIMIT_CYCLES) @(posedge CLK);
		$display("timeout: the tests did not finish within %0d clock cycles", LIMIT_CYCLES);
		abort_run();
	end

	initial begin : ASSERTION_WATCH
		wait (mem_subsystem_inst.memory_arbiter_inst.checker_inst.fail_count != 0);
		$display("an arbiter assertion failed during the run");
		abort_run();
	end

	initial begin : MAIN
		seed        = 51;
		CLK         = 1'b0;
		nRST        = 1'b0;
		redirect    = 1'b0;
		redirect_pc = '0;
		instr_ready = 1'b0;
		ls_req      = '0;
		repeat (4) @(posedge CLK);
		@(negedge CLK);
		nRST = 1'b1;

		word_round_trip();
		subword_access();
		load_program();
		sequential_fetch();
		back_pressure();
		mid_stream_redirect();
		shared_contention();

		@(negedge CLK);
		$display("TB PASSED");
		$finish;
	end

endmodule

/* all.f */
+incdir+source
source/mem_bus_pkg.sv
source/memory_arbiter.sv
source/instr_fetch_unit.sv
source/load_store_unit.sv
source/wait_state_ram.sv
source/mem_subsystem.sv
tb/mem_subsystem_checker.sv
tb/tb_mem_subsystem.sv

/* Bender.yml */
package:
  name: mem_subsystem

sources:
  - include_dirs:
      - source
    files:
      - source/mem_bus_pkg.sv
      - source/memory_arbiter.sv
      - source/instr_fetch_unit.sv
      - source/load_store_unit.sv
      - source/wait_state_ram.sv
      - source/mem_subsystem.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/mem_subsystem_checker.sv
      - tb/tb_mem_subsystem.sv
